//--- design/alu_exec.sv
`timescale 1ns/1ns

module alu_exec (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cke,

    input  logic                   issue_valid,
    input  regfile_pkg::instr_u    issue_instr,

    output regfile_pkg::reg_addr_t rs1_addr,
    output regfile_pkg::reg_addr_t rs2_addr,
    input  regfile_pkg::word_t     rs1_data,
    input  regfile_pkg::word_t     rs2_data,

    output logic                   wr_en,
    output regfile_pkg::reg_addr_t wr_addr,
    output regfile_pkg::word_t     wr_din,
    output logic                   retire
);

    localparam int ext_width = regfile_pkg::data_width - regfile_pkg::imm_width;

    regfile_pkg::opcode_t   issue_op;
    regfile_pkg::word_t     issue_imm;

    logic                   s1_valid;
    regfile_pkg::opcode_t   s1_op;
    regfile_pkg::reg_addr_t s1_rd;
    regfile_pkg::word_t     s1_imm;

    regfile_pkg::word_t     alu_result;
    logic                   alu_write;

    // Decode in the issue cycle while operand addresses go straight to the RAMs
    assign issue_op  = issue_instr.r.opcode;
    assign rs1_addr  = issue_instr.r.rs1;
    assign rs2_addr  = issue_instr.r.rs2;       // Don't care for op_addi
    assign issue_imm = {{ext_width{issue_instr.i.imm[regfile_pkg::imm_width-1]}},
                        issue_instr.i.imm};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (cke) begin
            s1_valid <= issue_valid;
        end
    end

    // Fields travel with the read request
    always_ff @(posedge clk) begin
        if (cke && issue_valid) begin
            s1_op  <= issue_op;
            s1_rd  <= issue_instr.r.rd;
            s1_imm <= issue_imm;
        end
    end

    // Operands are valid here one cycle after the issue
    always_comb begin
        alu_result = '0;
        alu_write  = 1'b1;
        case (s1_op)
            regfile_pkg::op_add:  alu_result = rs1_data + rs2_data;
            regfile_pkg::op_sub:  alu_result = rs1_data - rs2_data;
            regfile_pkg::op_and:  alu_result = rs1_data & rs2_data;
            regfile_pkg::op_or:   alu_result = rs1_data | rs2_data;
            regfile_pkg::op_xor:  alu_result = rs1_data ^ rs2_data;
            regfile_pkg::op_addi: alu_result = rs1_data + s1_imm;
            default:              alu_write  = 1'b0;   // op_nop and spare codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire <= 1'b0;
            wr_en  <= 1'b0;
        end else if (cke) begin
            retire <= s1_valid;
            wr_en  <= s1_valid && alu_write;
        end
    end

    always_ff @(posedge clk) begin
        if (cke && s1_valid) begin
            wr_addr <= s1_rd;
            wr_din  <= alu_result;
        end
    end

    // An instruction issued during a stall would be dropped
    assert property (@(posedge clk) disable iff (!rst_n) issue_valid |-> cke)
    else $error("alu_exec: instruction issued while stalled");

endmodule

//--- design/alu_regfile_top.sv
`timescale 1ns/1ns

module alu_regfile_top (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  regfile_pkg::apb_addr_t paddr,
    input  regfile_pkg::word_t     pwdata,
    output regfile_pkg::word_t     prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic                   run;
    logic                   issue_valid;
    regfile_pkg::instr_u    issue_instr;
    logic                   retire;
    logic                   win_rd_en;
    regfile_pkg::reg_addr_t win_rd_addr;
    regfile_pkg::reg_addr_t rs1_addr;
    regfile_pkg::reg_addr_t rs2_addr;
    logic                   wr_en;
    regfile_pkg::reg_addr_t wr_addr;
    regfile_pkg::word_t     wr_din;

    regfile_pkg::word_t [regfile_pkg::read_ports-1:0] rd_dout;

    apb_ctrl_regs u_apb (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .run         (run),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .retire      (retire),
        .win_rd_en   (win_rd_en),
        .win_rd_addr (win_rd_addr),
        .win_rd_data (rd_dout[2])
    );

    alu_exec u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .cke         (run),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rd_dout[0]),
        .rs2_data    (rd_dout[1]),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_din      (wr_din),
        .retire      (retire)
    );

    // Ports 0 and 1 are the operands, port 2 the host window
    register_file_ram #(
        .read_ports (regfile_pkg::read_ports)
    ) u_regfile (
        .clk     (clk),
        .cke     (run),                         // Stalls while run is clear
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_din  (wr_din),
        .rd_en   ({win_rd_en, issue_valid, issue_valid}),
        .rd_addr ({win_rd_addr, rs2_addr, rs1_addr}),
        .rd_dout (rd_dout)
    );

endmodule

//--- design/apb_ctrl_regs.sv
`timescale 1ns/1ns

module apb_ctrl_regs (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  regfile_pkg::apb_addr_t paddr,
    input  regfile_pkg::word_t     pwdata,
    output regfile_pkg::word_t     prdata,
    output logic                   pready,
    output logic                   pslverr,

    output logic                   run,
    output logic                   issue_valid,
    output regfile_pkg::instr_u    issue_instr,
    input  logic                   retire,

    output logic                   win_rd_en,
    output regfile_pkg::reg_addr_t win_rd_addr,
    input  regfile_pkg::word_t     win_rd_data
);

    logic               setup;
    logic               access;
    logic               done;
    logic               sel_ctrl;
    logic               sel_instr;
    logic               sel_retired;
    logic               sel_win;
    logic               sel_none;
    logic               bad_access;
    logic               wr_accept;
    regfile_pkg::word_t retired_cnt;

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign done   = access && pready;         // Completing access cycle

    // Address decode
    assign sel_ctrl    = (paddr == regfile_pkg::addr_ctrl);
    assign sel_instr   = (paddr == regfile_pkg::addr_instr);
    assign sel_retired = (paddr == regfile_pkg::addr_retired);
    assign sel_win     = (paddr >= regfile_pkg::addr_reg_base) && (paddr[1:0] == 2'b00);
    assign sel_none    = !(sel_ctrl || sel_instr || sel_retired || sel_win);

    // Window is read only, and instructions need the slice running
    assign bad_access = sel_none
                     || (sel_win && pwrite)
                     || (sel_instr && pwrite && !run);

    // Ready and error are set up during the setup cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else if (setup) begin
            pready  <= !(sel_win && !pwrite);   // Window read waits on the RAM
            pslverr <= bad_access;
        end else if (access && !pready) begin
            pready  <= 1'b1;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
    end

    assign wr_accept = done && pwrite && !pslverr;

    assign issue_valid = wr_accept && sel_instr;
    assign issue_instr = regfile_pkg::instr_u'(pwdata);

    // RAM read in the first access cycle, data back in the second
    assign win_rd_en   = access && !pready && sel_win && !pwrite;
    assign win_rd_addr = paddr[regfile_pkg::addr_width+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (wr_accept && sel_ctrl) begin
            run <= pwdata[0];
        end
    end

    // A retire held over a stall is counted once, when the clock enable returns
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired_cnt <= '0;
        end else if (retire && run) begin
            retired_cnt <= retired_cnt + 1'b1;
        end
    end

    always_comb begin
        prdata = '0;                            // instr and unmapped read as 0
        if (sel_ctrl) begin
            prdata[0] = run;
        end else if (sel_retired) begin
            prdata = retired_cnt;
        end else if (sel_win) begin
            prdata = win_rd_data;
        end
    end

    // The master must hold the transfer until ready is seen
    assert property (@(posedge clk) disable iff (!rst_n) pready |-> psel && penable)
    else $error("apb_ctrl_regs: pready outside an access cycle");

endmodule

//--- design/ram_dualport.sv
`timescale 1ns/1ns

module ram_dualport (
    input  logic                   clk,

    input  logic                   port0_en,
    input  logic                   port0_we,
    input  regfile_pkg::reg_addr_t port0_addr,
    input  regfile_pkg::word_t     port0_din,

    input  logic                   port1_en,
    input  logic                   port1_we,
    input  regfile_pkg::reg_addr_t port1_addr,
    input  regfile_pkg::word_t     port1_din,
    output regfile_pkg::word_t     port1_dout
);

    regfile_pkg::word_t mem [regfile_pkg::regs];

    // Registers come up as zero, output register too
    initial begin
        for (int k = 0; k < regfile_pkg::regs; k++) begin
            mem[k] = '0;
        end
        port1_dout = '0;
    end

    always @(posedge clk) begin
        if (port0_en && port0_we) begin
            mem[port0_addr] <= port0_din;
        end
        if (port1_en) begin
            if (port1_we) begin
                mem[port1_addr] <= port1_din;
                port1_dout      <= port1_din;   // Write first
            end else begin
                port1_dout      <= mem[port1_addr];
            end
        end
    end

    // The register file steers each write to exactly one port
    assert property (@(posedge clk)
        !(port0_en && port0_we && port1_en && port1_we))
    else $error("ram_dualport: both ports write in the same cycle");

endmodule

//--- design/regfile_pkg.sv
package regfile_pkg;

    // Register file geometry, fixed by the instruction format
    localparam int addr_width = 5;
    localparam int regs       = 32;
    localparam int data_width = 32;
    localparam int read_ports = 3;    // Two operands plus host window

    localparam int imm_width  = 18;   // Signed immediate of the I form

    typedef logic [data_width-1:0] word_t;
    typedef logic [addr_width-1:0] reg_addr_t;
    typedef logic [7:0]            apb_addr_t;

    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_addi = 4'h6
    } opcode_t;

    // Register form
    typedef struct packed {
        opcode_t     opcode;   // [31:28]
        reg_addr_t   rd;       // [27:23]
        reg_addr_t   rs1;      // [22:18]
        reg_addr_t   rs2;      // [17:13]
        logic [12:0] unused;
    } instr_r_t;

    // Immediate form, shares opcode, rd and rs1 positions with the R form
    typedef struct packed {
        opcode_t                      opcode;
        reg_addr_t                    rd;
        reg_addr_t                    rs1;
        logic signed [imm_width-1:0] imm;      // [17:0]
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // APB address map
    localparam apb_addr_t addr_ctrl     = 8'h00;  // Bit 0 is run
    localparam apb_addr_t addr_instr    = 8'h04;  // Write only
    localparam apb_addr_t addr_retired  = 8'h08;  // Read only
    localparam apb_addr_t addr_reg_base = 8'h80;  // Window up to 0xFC, read only

endpackage

//--- design/register_file_ram.sv
`timescale 1ns/1ns

module register_file_ram #(
    parameter int read_ports = 2
) (
    input  logic                                    clk,
    input  logic                                    cke,

    input  logic                                    wr_en,
    input  regfile_pkg::reg_addr_t                  wr_addr,
    input  regfile_pkg::word_t                      wr_din,

    input  logic [read_ports-1:0]                   rd_en,
    input  regfile_pkg::reg_addr_t [read_ports-1:0] rd_addr,
    output regfile_pkg::word_t [read_ports-1:0]     rd_dout
);

    // One RAM copy per read port, all copies receive every write
    for (genvar i = 0; i < read_ports; i++) begin : loop_ram
        logic overwrite;

        // Same-address read takes the write through port 1
        always_comb begin
            overwrite = 1'b0;
            if (rd_en[i] && (rd_addr[i] == wr_addr)) begin
                overwrite = 1'b1;
            end
        end

        ram_dualport u_ram (
            .clk        (clk),

            .port0_en   (cke),
            .port0_we   (wr_en && !overwrite),
            .port0_addr (wr_addr),
            .port0_din  (wr_din),

            .port1_en   (cke && rd_en[i]),
            .port1_we   (wr_en && overwrite),
            .port1_addr (rd_addr[i]),
            .port1_din  (wr_din),
            .port1_dout (rd_dout[i])
        );
    end

    // An unknown write address would corrupt every copy differently
    assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr))
    else $error("register_file_ram: write with unknown address");

endmodule

//--- verif/alu_regfile_tb.sv
`timescale 1ns/1ns

module alu_regfile_tb;

    localparam int wait_limit = 20;   // Cycles allowed for pready

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    regfile_pkg::apb_addr_t paddr;
    regfile_pkg::word_t     pwdata;
    regfile_pkg::word_t     prdata;
    logic                   pready;
    logic                   pslverr;

    // Stimulus table with one entry per APB transfer
    string                  row_name[$];
    bit                     row_write[$];
    regfile_pkg::apb_addr_t row_addr[$];
    regfile_pkg::word_t     row_data[$];
    bit                     row_err[$];

    // Reference model
    regfile_pkg::word_t     model_regs [32];
    int unsigned            model_retired;
    logic                   model_run;

    alu_regfile_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input string name, input regfile_pkg::word_t exp,
                              input regfile_pkg::word_t act);
        if (act !== exp) begin
            report_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("error: %s pslverr expected %b actual %b", name, exp, act));
        end
    endtask

    // Drives setup then access and returns at the completing rising edge
    task automatic apb_transfer(input bit write, input regfile_pkg::apb_addr_t addr,
                                input regfile_pkg::word_t data,
                                output regfile_pkg::word_t rdata, output logic err);
        int cnt;
        cnt = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        while (!pready) begin
            if (cnt == wait_limit) begin
                report_failure($sformatf("pready never came for address %h", addr));
            end
            @(negedge clk);
            cnt++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic regfile_pkg::word_t encode_reg(regfile_pkg::opcode_t op, int rd,
                                                      int rs1, int rs2);
        return {op, 5'(rd), 5'(rs1), 5'(rs2), 13'b0};
    endfunction

    function automatic regfile_pkg::word_t encode_imm(int rd, int rs1, logic [17:0] imm);
        return {regfile_pkg::op_addi, 5'(rd), 5'(rs1), imm};
    endfunction

    function automatic regfile_pkg::apb_addr_t window_addr(int idx);
        return regfile_pkg::addr_reg_base + 8'(idx * 4);
    endfunction

    task automatic add_row(input string name, input bit write,
                           input regfile_pkg::apb_addr_t addr,
                           input regfile_pkg::word_t data, input bit err);
        row_name.push_back(name);
        row_write.push_back(write);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_err.push_back(err);
    endtask

    // Instruction fields are opcode [31:28], rd [27:23], rs1 [22:18], rs2 [17:13], imm [17:0]
    task automatic model_execute(input regfile_pkg::word_t instr);
        regfile_pkg::word_t a;
        regfile_pkg::word_t b;
        regfile_pkg::word_t imm;
        int                 rd;
        a   = model_regs[instr[22:18]];
        b   = model_regs[instr[17:13]];
        imm = {{14{instr[17]}}, instr[17:0]};
        rd  = instr[27:23];
        case (instr[31:28])
            regfile_pkg::op_add:  model_regs[rd] = a + b;
            regfile_pkg::op_sub:  model_regs[rd] = a - b;
            regfile_pkg::op_and:  model_regs[rd] = a & b;
            regfile_pkg::op_or:   model_regs[rd] = a | b;
            regfile_pkg::op_xor:  model_regs[rd] = a ^ b;
            regfile_pkg::op_addi: model_regs[rd] = a + imm;
            default: ;                                  // nop writes nothing
        endcase
        model_retired++;
    endtask

    function automatic regfile_pkg::word_t expected_read(regfile_pkg::apb_addr_t addr);
        if (addr == regfile_pkg::addr_ctrl) return {31'b0, model_run};
        if (addr == regfile_pkg::addr_retired) return model_retired;
        if (addr >= regfile_pkg::addr_reg_base) return model_regs[addr[6:2]];
        return '0;
    endfunction

    task automatic build_table();
        logic [17:0] imm;
        add_row("reset_ctrl", 0, regfile_pkg::addr_ctrl, '0, 0);
        add_row("reset_retired", 0, regfile_pkg::addr_retired, '0, 0);
        add_row("run_on", 1, regfile_pkg::addr_ctrl, 32'h1, 0);
        add_row("read_run", 0, regfile_pkg::addr_ctrl, '0, 0);
        add_row("reset_r0", 0, window_addr(0), '0, 0);   // RAM reads need run set
        add_row("reset_r17", 0, window_addr(17), '0, 0);
        add_row("reset_r31", 0, window_addr(31), '0, 0);
        for (int k = 1; k <= 6; k++) begin
            imm = 18'($urandom());
            add_row($sformatf("addi_r%0d", k), 1, regfile_pkg::addr_instr,
                    encode_imm(k, 0, imm), 0);
        end
        for (int k = 6; k >= 1; k--) begin               // r6 first catches the bypass
            add_row($sformatf("load_r%0d", k), 0, window_addr(k), '0, 0);
        end
        // Each instruction reads the rd of the one before it
        add_row("add_r7", 1, regfile_pkg::addr_instr, encode_reg(regfile_pkg::op_add, 7, 1, 2), 0);
        add_row("sub_r8", 1, regfile_pkg::addr_instr, encode_reg(regfile_pkg::op_sub, 8, 7, 3), 0);
        add_row("and_r9", 1, regfile_pkg::addr_instr, encode_reg(regfile_pkg::op_and, 9, 8, 4), 0);
        add_row("or_r10", 1, regfile_pkg::addr_instr, encode_reg(regfile_pkg::op_or, 10, 9, 5), 0);
        add_row("xor_r11", 1, regfile_pkg::addr_instr,
                encode_reg(regfile_pkg::op_xor, 11, 10, 6), 0);
        add_row("addi_r12", 1, regfile_pkg::addr_instr, encode_imm(12, 11, 18'h3_FFF9), 0);
        add_row("sub_r13", 1, regfile_pkg::addr_instr,
                encode_reg(regfile_pkg::op_sub, 13, 1, 12), 0);
        add_row("xor_r14", 1, regfile_pkg::addr_instr,
                encode_reg(regfile_pkg::op_xor, 14, 13, 13), 0);
        for (int k = 7; k <= 14; k++) begin
            add_row($sformatf("alu_r%0d", k), 0, window_addr(k), '0, 0);
        end
        add_row("nop", 1, regfile_pkg::addr_instr, encode_reg(regfile_pkg::op_nop, 1, 2, 3), 0);
        add_row("nop_keeps_r1", 0, window_addr(1), '0, 0);
        add_row("retired_count", 0, regfile_pkg::addr_retired, '0, 0);
        add_row("read_instr", 0, regfile_pkg::addr_instr, '0, 0);
        add_row("run_off", 1, regfile_pkg::addr_ctrl, 32'h0, 0);
        add_row("instr_stopped", 1, regfile_pkg::addr_instr,
                encode_reg(regfile_pkg::op_add, 1, 2, 3), 1);
        add_row("run_again", 1, regfile_pkg::addr_ctrl, 32'h1, 0);
        add_row("window_write", 1, window_addr(1), 32'hDEAD_BEEF, 1);
        add_row("unmapped_read", 0, 8'h40, '0, 1);
        add_row("unmapped_write", 1, 8'h0C, 32'h5, 1);
        add_row("final_r1", 0, window_addr(1), '0, 0);
        add_row("final_retired", 0, regfile_pkg::addr_retired, '0, 0);
    endtask

    initial begin
        regfile_pkg::word_t rdata;
        logic               rerr;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(70));
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        model_retired = 0;
        model_run     = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < row_name.size(); n++) begin
            apb_transfer(row_write[n], row_addr[n], row_data[n], rdata, rerr);
            check_err(row_name[n], row_err[n], rerr);
            if (!row_err[n] && row_write[n]) begin
                if (row_addr[n] == regfile_pkg::addr_ctrl) begin
                    model_run = row_data[n][0];
                end else if (row_addr[n] == regfile_pkg::addr_instr) begin
                    model_execute(row_data[n]);
                end
            end else if (!row_err[n]) begin
                check_word(row_name[n], expected_read(row_addr[n]), rdata);
            end
        end
        bus_idle();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- verilog.f
design/regfile_pkg.sv
design/ram_dualport.sv
design/register_file_ram.sv
design/alu_exec.sv
design/apb_ctrl_regs.sv
design/alu_regfile_top.sv
verif/alu_regfile_tb.sv
